// ==== Bender.yml ====
package:
  name: triangle_memory

sources:
  - hw/tri_pkg.sv
  - hw/single_port_ram.sv
  - hw/triangle_store.sv
  - hw/triangle_walker.sv
  - hw/triangle_memory_top.sv
  - target: simulation
    files:
      - verification/triangle_memory_assertions.sv
      - verification/tb_triangle_memory.sv

// ==== hw/single_port_ram.sv ====
`timescale 1ns/1ps

module single_port_ram #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] data,
    output logic [DATA_WIDTH-1:0] q
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // read is registered every cycle, returns old data on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

// ==== hw/tri_pkg.sv ====
package tri_pkg;

    // scene capacity
    localparam int num_triangles = 512;
    localparam int tri_id_w = $clog2(num_triangles);
    // four index words per triangle
    localparam int addr_w = tri_id_w + 2;
    localparam int coord_w = 32;
    localparam int vertex_w = 3 * coord_w;

    // store states, read states kept consecutive
    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_ld_index  = 3'd1;
    localparam logic [2:0] st_ld_vertex = 3'd2;
    localparam logic [2:0] st_rd_1      = 3'd3;
    localparam logic [2:0] st_rd_2      = 3'd4;
    localparam logic [2:0] st_rd_3      = 3'd5;
    localparam logic [2:0] st_rd_4      = 3'd6;

    // walker states
    localparam logic [1:0] wk_idle = 2'd0;
    localparam logic [1:0] wk_wait = 2'd1;
    localparam logic [1:0] wk_last = 2'd2;

    // one load word, read as index record or as vertex record
    typedef union packed {
        struct packed {
            logic [coord_w-1:0] sid;
            logic [coord_w-1:0] v2;
            logic [coord_w-1:0] v1;
            logic [coord_w-1:0] v0;
        } idx;
        struct packed {
            logic [coord_w-1:0] flag;
            logic [coord_w-1:0] z;
            logic [coord_w-1:0] y;
            logic [coord_w-1:0] x;
        } vtx;
    } load_word_t;

endpackage

// ==== hw/triangle_memory_top.sv ====
`timescale 1ns/1ps

module triangle_memory_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load_we,
    input  tri_pkg::load_word_t          load_word,
    output logic                         load_rdy,
    input  logic                         scan_start,
    output logic                         tri_valid,
    output logic [tri_pkg::tri_id_w-1:0] tri_id,
    output logic [tri_pkg::vertex_w-1:0] vertex0,
    output logic [tri_pkg::vertex_w-1:0] vertex1,
    output logic [tri_pkg::vertex_w-1:0] vertex2,
    output logic [tri_pkg::coord_w-1:0]  sid,
    output logic                         scan_done,
    output logic [tri_pkg::tri_id_w:0]   tri_count
);

    // walker to store request path
    logic                         walk_re;
    logic [tri_pkg::tri_id_w-1:0] walk_id;
    logic                         store_rdy;
    logic                         store_not_valid;
    logic [tri_pkg::vertex_w-1:0] store_vertex0;
    logic [tri_pkg::vertex_w-1:0] store_vertex1;
    logic [tri_pkg::vertex_w-1:0] store_vertex2;
    logic [tri_pkg::coord_w-1:0]  store_sid;

    triangle_store u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .we_mc      (load_we),
        .data_mc    (load_word),
        .rdy_mc     (load_rdy),
        .re         (walk_re),
        .triangle_id(walk_id),
        .rdy        (store_rdy),
        .not_valid  (store_not_valid),
        .vertex0    (store_vertex0),
        .vertex1    (store_vertex1),
        .vertex2    (store_vertex2),
        .sid        (store_sid)
    );

    triangle_walker u_walker (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_start (scan_start),
        .re         (walk_re),
        .triangle_id(walk_id),
        .rdy        (store_rdy),
        .not_valid  (store_not_valid),
        .vertex0_in (store_vertex0),
        .vertex1_in (store_vertex1),
        .vertex2_in (store_vertex2),
        .sid_in     (store_sid),
        .tri_valid  (tri_valid),
        .tri_id     (tri_id),
        .vertex0    (vertex0),
        .vertex1    (vertex1),
        .vertex2    (vertex2),
        .sid        (sid),
        .scan_done  (scan_done),
        .tri_count  (tri_count)
    );

endmodule

// ==== hw/triangle_store.sv ====
`timescale 1ns/1ps

module triangle_store (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         we_mc,
    input  tri_pkg::load_word_t          data_mc,
    output logic                         rdy_mc,
    input  logic                         re,
    input  logic [tri_pkg::tri_id_w-1:0] triangle_id,
    output logic                         rdy,
    output logic                         not_valid,
    output logic [tri_pkg::vertex_w-1:0] vertex0,
    output logic [tri_pkg::vertex_w-1:0] vertex1,
    output logic [tri_pkg::vertex_w-1:0] vertex2,
    output logic [tri_pkg::coord_w-1:0]  sid
);

    logic [2:0] state;
    logic [2:0] state_nxt;

    // load sequencer
    tri_pkg::load_word_t ld_word;
    logic ld_active;
    logic [1:0] ld_cnt;
    // one extra bit so a full store still counts correctly
    logic [tri_pkg::addr_w:0] ld_addr;
    logic [tri_pkg::tri_id_w:0] tri_total;
    logic ld_start;
    logic ld_switch;
    logic loading;

    // read side
    logic reading;
    logic in_range;
    logic [tri_pkg::tri_id_w-1:0] rd_id;
    logic rd_demand;
    logic buf_ok;
    logic [tri_pkg::tri_id_w-1:0] nxt_id;
    logic pf_pending;
    logic issue;
    logic [tri_pkg::tri_id_w-1:0] issue_id;
    logic serve;
    logic abort;
    logic fill;

    // memory ports
    logic idx_we;
    logic crd_we;
    logic [tri_pkg::addr_w-1:0] idx_addr;
    logic [tri_pkg::addr_w-1:0] crd_addr;
    logic [tri_pkg::coord_w-1:0] idx_data;
    logic [tri_pkg::coord_w-1:0] idx_q;
    logic [tri_pkg::coord_w-1:0] crd_data [3];
    logic [tri_pkg::coord_w-1:0] crd_q [3];
    logic [tri_pkg::vertex_w-1:0] crd_vertex;

    assign loading = (state == tri_pkg::st_ld_index) || (state == tri_pkg::st_ld_vertex);
    assign reading = (state == tri_pkg::st_rd_1) || (state == tri_pkg::st_rd_2) ||
                     (state == tri_pkg::st_rd_3) || (state == tri_pkg::st_rd_4);
    assign ld_start = we_mc && !loading;
    // zero surface id at the start of a record closes the index phase
    assign ld_switch = (state == tri_pkg::st_ld_index) && ld_active && (ld_cnt == 2'd0) &&
                       (ld_word.idx.sid == '0);
    assign in_range = {1'b0, triangle_id} < tri_total;
    assign crd_vertex = {crd_q[2], crd_q[1], crd_q[0]};

    always_comb begin
        state_nxt = state;
        idx_we = 1'b0;
        crd_we = 1'b0;
        idx_addr = {rd_id, 2'd0};
        idx_data = ld_word.idx.v0;
        // read states chase the vertex index coming out of the index memory
        crd_addr = idx_q[tri_pkg::addr_w-1:0];
        rdy_mc = 1'b0;
        issue = 1'b0;
        issue_id = triangle_id;
        serve = 1'b0;
        abort = 1'b0;
        fill = 1'b0;
        case (state)
            tri_pkg::st_ld_index: begin
                idx_addr = ld_addr[tri_pkg::addr_w-1:0];
                if (ld_switch) begin
                    rdy_mc = 1'b1;
                    state_nxt = tri_pkg::st_ld_vertex;
                end else if (ld_active) begin
                    idx_we = 1'b1;
                    rdy_mc = (ld_cnt == 2'd3);
                    case (ld_cnt)
                        2'd0: idx_data = ld_word.idx.v0;
                        2'd1: idx_data = ld_word.idx.v1;
                        2'd2: idx_data = ld_word.idx.v2;
                        default: idx_data = ld_word.idx.sid;
                    endcase
                end
            end
            tri_pkg::st_ld_vertex: begin
                crd_addr = ld_addr[tri_pkg::addr_w-1:0];
                if (ld_active) begin
                    rdy_mc = 1'b1;
                    if (ld_word.vtx.flag == '0) begin
                        state_nxt = tri_pkg::st_idle;
                    end else begin
                        crd_we = 1'b1;
                    end
                end
            end
            tri_pkg::st_idle: begin
                if (re && !in_range) begin
                    abort = 1'b1;
                end else if (re && buf_ok && (triangle_id == rd_id)) begin
                    // prefetched triangle already in the buffers
                    serve = 1'b1;
                end else if (re) begin
                    issue = 1'b1;
                end else if (pf_pending) begin
                    issue = 1'b1;
                    issue_id = nxt_id;
                end
            end
            default: begin
                if (re && !in_range) begin
                    abort = 1'b1;
                    state_nxt = tri_pkg::st_idle;
                end else if (re && (triangle_id != rd_id)) begin
                    // wrong triangle in flight, start over
                    issue = 1'b1;
                end else begin
                    case (state)
                        tri_pkg::st_rd_1: begin
                            idx_addr = {rd_id, 2'd1};
                            state_nxt = tri_pkg::st_rd_2;
                        end
                        tri_pkg::st_rd_2: begin
                            idx_addr = {rd_id, 2'd2};
                            state_nxt = tri_pkg::st_rd_3;
                        end
                        tri_pkg::st_rd_3: begin
                            idx_addr = {rd_id, 2'd3};
                            state_nxt = tri_pkg::st_rd_4;
                        end
                        default: begin
                            fill = 1'b1;
                            serve = rd_demand || re;
                            state_nxt = tri_pkg::st_idle;
                        end
                    endcase
                end
            end
        endcase
        if (issue) begin
            idx_addr = {issue_id, 2'd0};
            state_nxt = tri_pkg::st_rd_1;
        end
        if (ld_start) begin
            state_nxt = tri_pkg::st_ld_index;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tri_pkg::st_idle;
            ld_active <= 1'b0;
            ld_cnt <= '0;
            ld_addr <= '0;
            tri_total <= '0;
            rd_id <= '0;
            rd_demand <= 1'b0;
            buf_ok <= 1'b0;
            nxt_id <= '0;
            pf_pending <= 1'b0;
            rdy <= 1'b0;
            not_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            rdy <= serve;
            not_valid <= abort;
            if (we_mc) begin
                ld_active <= 1'b1;
            end else if (rdy_mc) begin
                ld_active <= 1'b0;
            end
            if (we_mc) begin
                ld_cnt <= '0;
            end else if (idx_we) begin
                ld_cnt <= ld_cnt + 2'd1;
            end
            if (ld_start || ld_switch) begin
                ld_addr <= '0;
            end else if (idx_we || crd_we) begin
                ld_addr <= ld_addr + 1'b1;
            end
            // record count is the index word address over four
            if (ld_start) begin
                tri_total <= '0;
            end else if (ld_switch) begin
                tri_total <= ld_addr[tri_pkg::addr_w:2];
            end
            if (issue) begin
                rd_id <= issue_id;
                rd_demand <= re;
            end else if (abort || serve) begin
                rd_demand <= 1'b0;
            end else if (re && reading) begin
                rd_demand <= 1'b1;
            end
            if (issue || ld_start) begin
                buf_ok <= 1'b0;
            end else if (fill) begin
                buf_ok <= 1'b1;
            end
            // queue the next id once a request is answered
            if (serve) begin
                pf_pending <= ({1'b0, rd_id} + 1'b1) < tri_total;
                nxt_id <= rd_id + 1'b1;
            end else if (issue || abort || ld_start) begin
                pf_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_mc) begin
            ld_word <= data_mc;
        end
    end

    // output buffers, filled as the coordinates come back
    always_ff @(posedge clk) begin
        if (state == tri_pkg::st_rd_2) begin
            vertex0 <= crd_vertex;
        end
        if (state == tri_pkg::st_rd_3) begin
            vertex1 <= crd_vertex;
        end
        if (fill) begin
            vertex2 <= crd_vertex;
            sid <= idx_q;
        end
    end

    single_port_ram #(
        .ADDR_WIDTH(tri_pkg::addr_w),
        .DATA_WIDTH(tri_pkg::coord_w)
    ) u_index_ram (
        .clk (clk),
        .we  (idx_we),
        .addr(idx_addr),
        .data(idx_data),
        .q   (idx_q)
    );

    assign crd_data[0] = ld_word.vtx.x;
    assign crd_data[1] = ld_word.vtx.y;
    assign crd_data[2] = ld_word.vtx.z;

    // x, y and z planes share one address
    for (genvar i = 0; i < 3; i++) begin : gen_coord
        single_port_ram #(
            .ADDR_WIDTH(tri_pkg::addr_w),
            .DATA_WIDTH(tri_pkg::coord_w)
        ) u_coord_ram (
            .clk (clk),
            .we  (crd_we),
            .addr(crd_addr),
            .data(crd_data[i]),
            .q   (crd_q[i])
        );
    end

endmodule

// ==== hw/triangle_walker.sv ====
`timescale 1ns/1ps

module triangle_walker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         scan_start,
    output logic                         re,
    output logic [tri_pkg::tri_id_w-1:0] triangle_id,
    input  logic                         rdy,
    input  logic                         not_valid,
    input  logic [tri_pkg::vertex_w-1:0] vertex0_in,
    input  logic [tri_pkg::vertex_w-1:0] vertex1_in,
    input  logic [tri_pkg::vertex_w-1:0] vertex2_in,
    input  logic [tri_pkg::coord_w-1:0]  sid_in,
    output logic                         tri_valid,
    output logic [tri_pkg::tri_id_w-1:0] tri_id,
    output logic [tri_pkg::vertex_w-1:0] vertex0,
    output logic [tri_pkg::vertex_w-1:0] vertex1,
    output logic [tri_pkg::vertex_w-1:0] vertex2,
    output logic [tri_pkg::coord_w-1:0]  sid,
    output logic                         scan_done,
    output logic [tri_pkg::tri_id_w:0]   tri_count
);

    logic [1:0] state;
    // id being requested, also the number delivered so far
    logic [tri_pkg::tri_id_w:0] next_id;
    logic last_id;

    // store is full at this id, no out-of-range id to ask for
    assign last_id = &next_id[tri_pkg::tri_id_w-1:0];
    assign triangle_id = next_id[tri_pkg::tri_id_w-1:0];
    assign tri_count = next_id;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tri_pkg::wk_idle;
            next_id <= '0;
            re <= 1'b0;
            tri_valid <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            re <= 1'b0;
            tri_valid <= 1'b0;
            scan_done <= 1'b0;
            case (state)
                tri_pkg::wk_idle: begin
                    if (scan_start) begin
                        next_id <= '0;
                        re <= 1'b1;
                        state <= tri_pkg::wk_wait;
                    end
                end
                tri_pkg::wk_wait: begin
                    if (rdy) begin
                        tri_valid <= 1'b1;
                        next_id <= next_id + 1'b1;
                        if (last_id) begin
                            state <= tri_pkg::wk_last;
                        end else begin
                            re <= 1'b1;
                        end
                    end else if (not_valid) begin
                        scan_done <= 1'b1;
                        state <= tri_pkg::wk_idle;
                    end
                end
                tri_pkg::wk_last: begin
                    scan_done <= 1'b1;
                    state <= tri_pkg::wk_idle;
                end
                default: state <= tri_pkg::wk_idle;
            endcase
        end
    end

    // result registers
    always_ff @(posedge clk) begin
        if ((state == tri_pkg::wk_wait) && rdy) begin
            tri_id <= triangle_id;
            vertex0 <= vertex0_in;
            vertex1 <= vertex1_in;
            vertex2 <= vertex2_in;
            sid <= sid_in;
        end
    end

endmodule

// ==== src.f ====
hw/tri_pkg.sv
hw/single_port_ram.sv
hw/triangle_store.sv
hw/triangle_walker.sv
hw/triangle_memory_top.sv
verification/triangle_memory_assertions.sv
verification/tb_triangle_memory.sv

// ==== verification/tb_triangle_memory.sv ====
`timescale 1ns/1ps

module tb_triangle_memory;

    localparam int period = 100;
    localparam int max_tris = 32;
    localparam int max_verts = 64;

    logic clk;
    logic rst_n;
    logic load_we;
    tri_pkg::load_word_t load_word;
    logic load_rdy;
    logic scan_start;
    logic tri_valid;
    logic [tri_pkg::tri_id_w-1:0] tri_id;
    logic [tri_pkg::vertex_w-1:0] vertex0;
    logic [tri_pkg::vertex_w-1:0] vertex1;
    logic [tri_pkg::vertex_w-1:0] vertex2;
    logic [tri_pkg::coord_w-1:0] sid;
    logic scan_done;
    logic [tri_pkg::tri_id_w:0] tri_count;

    integer seed;
    int errors;
    int checks;
    string test_name;

    // scene model, coordinates stored as x, y, z
    int n_tris;
    int n_verts;
    logic [tri_pkg::coord_w-1:0] m_sid [max_tris];
    int m_idx [max_tris][3];
    logic [tri_pkg::coord_w-1:0] m_crd [max_verts][3];

    triangle_memory_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_we   (load_we),
        .load_word (load_word),
        .load_rdy  (load_rdy),
        .scan_start(scan_start),
        .tri_valid (tri_valid),
        .tri_id    (tri_id),
        .vertex0   (vertex0),
        .vertex1   (vertex1),
        .vertex2   (vertex2),
        .sid       (sid),
        .scan_done (scan_done),
        .tri_count (tri_count)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    task automatic check_vertex(input string name, input logic [tri_pkg::vertex_w-1:0] exp,
                                input logic [tri_pkg::vertex_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: vertex expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_sid(input string name, input logic [tri_pkg::coord_w-1:0] exp,
                             input logic [tri_pkg::coord_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: sid expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [tri_pkg::tri_id_w:0] exp,
                               input logic [tri_pkg::tri_id_w:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: count expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_id(input string name, input logic [tri_pkg::tri_id_w-1:0] exp,
                            input logic [tri_pkg::tri_id_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: tri_id expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic int random_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // vertex as the DUT presents it, z on top
    function automatic logic [tri_pkg::vertex_w-1:0] expected_vertex(input int k);
        return {m_crd[k][2], m_crd[k][1], m_crd[k][0]};
    endfunction

    function automatic int est_cycles(input int ntri, input int nvert, input int gap_max,
                                      input int scans);
        return (ntri + 1) * (6 + gap_max) + (nvert + 1) * (3 + gap_max) +
               scans * (10 * (ntri + 2) + 12);
    endfunction

    // one word, then hold off until the store answers
    task automatic send_record(input tri_pkg::load_word_t w, input int gap);
        int waited;
        waited = 0;
        repeat (gap) @(negedge clk);
        @(negedge clk);
        load_word = w;
        load_we = 1'b1;
        @(negedge clk);
        load_we = 1'b0;
        while (!load_rdy && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!load_rdy) begin
            errors++;
            $display("%s: load_rdy never answered a load word", test_name);
        end
    endtask

    task automatic load_scene(input int gap_max);
        tri_pkg::load_word_t w;
        for (int i = 0; i < n_tris; i++) begin
            w.idx.sid = m_sid[i];
            w.idx.v2 = m_idx[i][2];
            w.idx.v1 = m_idx[i][1];
            w.idx.v0 = m_idx[i][0];
            send_record(w, (gap_max > 0) ? random_below(gap_max + 1) : 0);
        end
        w = '0;
        send_record(w, 0);
        for (int k = 0; k < n_verts; k++) begin
            w.vtx.flag = 32'h1;
            w.vtx.z = m_crd[k][2];
            w.vtx.y = m_crd[k][1];
            w.vtx.x = m_crd[k][0];
            send_record(w, (gap_max > 0) ? random_below(gap_max + 1) : 0);
        end
        w = '0;
        send_record(w, 0);
    endtask

    task automatic random_scene(input int ntri, input int nvert);
        n_tris = ntri;
        n_verts = nvert;
        for (int k = 0; k < nvert; k++) begin
            for (int c = 0; c < 3; c++) begin
                m_crd[k][c] = $random(seed);
            end
        end
        for (int i = 0; i < ntri; i++) begin
            m_sid[i] = $random(seed);
            // zero sid would end the index phase
            if (m_sid[i] == '0) begin
                m_sid[i] = 32'h1;
            end
            for (int c = 0; c < 3; c++) begin
                m_idx[i][c] = random_below(nvert);
            end
        end
    endtask

    task automatic run_scan();
        int seen;
        int waited;
        seen = 0;
        waited = 0;
        @(negedge clk);
        scan_start = 1'b1;
        @(negedge clk);
        scan_start = 1'b0;
        while (!scan_done && waited < 10 * (n_tris + 2)) begin
            if (tri_valid && seen >= n_tris) begin
                errors++;
                $display("%s: more triangles delivered than loaded", test_name);
            end else if (tri_valid) begin
                check_id(test_name, seen, tri_id);
                check_vertex(test_name, expected_vertex(m_idx[seen][0]), vertex0);
                check_vertex(test_name, expected_vertex(m_idx[seen][1]), vertex1);
                check_vertex(test_name, expected_vertex(m_idx[seen][2]), vertex2);
                check_sid(test_name, m_sid[seen], sid);
            end
            seen += tri_valid;
            @(negedge clk);
            waited++;
        end
        if (!scan_done) begin
            errors++;
            $display("%s: scan did not finish in time", test_name);
        end else begin
            check_count(test_name, n_tris, tri_count);
            check_count(test_name, n_tris, seen);
        end
        // the scan is over, nothing more may arrive
        repeat (8) begin
            @(negedge clk);
            if (tri_valid) begin
                errors++;
                $display("%s: tri_valid after scan_done", test_name);
            end
        end
    endtask

    task automatic test_single();
        test_name = "single";
        n_tris = 1;
        n_verts = 3;
        for (int k = 0; k < 3; k++) begin
            for (int c = 0; c < 3; c++) begin
                m_crd[k][c] = 32'h1000_0000 + (k << 8) + c;
            end
        end
        m_idx[0][0] = 2;
        m_idx[0][1] = 0;
        m_idx[0][2] = 1;
        m_sid[0] = 32'h0000_00a5;
        load_scene(0);
        run_scan();
        // second scan is answered from the prefetch buffers
        run_scan();
    endtask

    task automatic test_shared();
        test_name = "shared";
        // 18 picks over 5 vertices share many of them
        random_scene(6, 5);
        load_scene(0);
        run_scan();
    endtask

    task automatic test_prefetch();
        test_name = "prefetch";
        random_scene(20, 40);
        load_scene(0);
        run_scan();
    endtask

    task automatic test_range_end();
        test_name = "range_end";
        random_scene(9, 12);
        load_scene(0);
        run_scan();
        run_scan();
    endtask

    task automatic test_reload();
        test_name = "reload";
        random_scene(16, 24);
        load_scene(0);
        run_scan();
        random_scene(5, 7);
        load_scene(0);
        run_scan();
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        random_scene(12, 18);
        load_scene(6);
        run_scan();
    endtask

    initial begin
        int budget;
        budget = 6 + est_cycles(1, 3, 0, 2) + est_cycles(6, 5, 0, 1) +
                 est_cycles(20, 40, 0, 1) + est_cycles(9, 12, 0, 2) +
                 est_cycles(16, 24, 0, 1) + est_cycles(5, 7, 0, 1) + est_cycles(12, 18, 6, 1);
        #(budget * 8 * period);
        $display("timeout: tests still running, checks %0d, errors %0d", checks, errors);
        $display("Something failed");
        $finish;
    end

    initial begin
        seed = 29;
        errors = 0;
        checks = 0;
        rst_n = 1'b0;
        load_we = 1'b0;
        load_word = '0;
        scan_start = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_single();
        test_shared();
        test_prefetch();
        test_range_end();
        test_reload();
        test_backpressure();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verification/triangle_memory_assertions.sv ====
`timescale 1ns/1ps

module triangle_memory_assertions (
    input logic clk,
    input logic rst_n,
    input logic load_we,
    input logic load_rdy,
    input logic tri_valid,
    input logic scan_done
);

    // a triangle and the end of a scan never share a cycle
    a_valid_done_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(tri_valid && scan_done))
        else $error("tri_valid and scan_done high in the same cycle");

    // vertex and terminator records answer next cycle, index records after four
    a_rdy_after_we: assert property (@(posedge clk) disable iff (!rst_n)
        load_rdy |-> ($past(load_we, 1) || $past(load_we, 4)))
        else $error("load_rdy without a matching load_we");

    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!load_rdy && !tri_valid && !scan_done))
        else $error("output pulse high right after reset");

endmodule

bind triangle_memory_top triangle_memory_assertions u_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .load_we  (load_we),
    .load_rdy (load_rdy),
    .tri_valid(tri_valid),
    .scan_done(scan_done)
);
